//--- Makefile
# Verilator build and run for the bus subsystem testbench

TOP := tcb_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- include/tcb_cfg_cfg.svh
// bus widths, address map and register constants, included by the package and the RTL
`ifndef TCB_CFG_CFG_SVH
`define TCB_CFG_CFG_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// one data word
`define TCB_DAT_W 32
// byte address
`define TCB_ADR_W 16
// one enable per byte lane
`define TCB_BYT_W 4

//////////////////////////////
// address map
//////////////////////////////

// region code lives in adr[15:12]
`define TCB_REGION_SRAM 4'h0
`define TCB_REGION_REGS 4'h1

// sram size in words
`define TCB_SRAM_DEPTH 256

// identification register, read-only
`define TCB_REGS_ID 32'h7cb1_0a01

`endif

//--- logic/tcb_addr_decoder.sv
// address decoder, turns the request address into a subordinate select for the demultiplexer
`timescale 1ns/100ps
`include "tcb_cfg_cfg.svh"

module tcb_addr_decoder
    import tcb_pkg::*;
(
    // request address from the manager
    input  tcb_adr_t adr,
    // 0 selects sram, 1 selects the register block
    output logic     sel
);

    //////////////////////////////
    // local signals
    //////////////////////////////

    // word offset width inside a region
    localparam int unsigned wow = `TCB_ADR_W - 6;

    // sram size as a word count
    localparam int unsigned sram_depth = `TCB_SRAM_DEPTH;

    // memory view of the address
    tcb_adr_mem_t mem_adr;

    // word offset within the region
    logic [wow-1:0] word_off;

    // partial hits
    logic region_hit;
    logic depth_hit;

    //////////////////////////////
    // decode
    //////////////////////////////

    // decoder only ever looks at the memory view
    assign mem_adr = adr.mem;

    // drop the byte lane bits
    assign word_off = mem_adr.off[`TCB_ADR_W-5:2];

    // region code match
    assign region_hit = (mem_adr.region == `TCB_REGION_SRAM);

    // inside the implemented sram words
    assign depth_hit = (word_off < wow'(sram_depth));

    // everything else falls to the register block
    // which answers unmapped addresses with an error
    assign sel = ~(region_hit & depth_hit);

endmodule: tcb_addr_decoder

//--- logic/tcb_demultiplexer.sv
// bus demultiplexer, routes manager requests to one of ifn subordinates and returns the response
`timescale 1ns/100ps

module tcb_demultiplexer
    import tcb_pkg::*;
#(
    // number of subordinate ports
    parameter  int unsigned ifn = 2,
    // select width
    localparam int unsigned ifl = (ifn > 1) ? $clog2(ifn) : 1
)(
    // clock and reset
    input  logic           sub,
    input  logic           rst_n,
    // port select from the decoder
    input  logic [ifl-1:0] sel,
    // manager side
    input  logic           vld,
    input  logic           wen,
    input  tcb_adr_t       adr,
    input  tcb_byt_t       byt,
    input  tcb_dat_t       wdt,
    output logic           rdy,
    output tcb_dat_t       rdt,
    output logic           err,
    // subordinate side, requests
    output logic           m_vld [ifn-1:0],
    output logic           m_wen [ifn-1:0],
    output tcb_adr_t       m_adr [ifn-1:0],
    output tcb_byt_t       m_byt [ifn-1:0],
    output tcb_dat_t       m_wdt [ifn-1:0],
    // subordinate side, responses
    input  logic           m_rdy [ifn-1:0],
    input  tcb_dat_t       m_rdt [ifn-1:0],
    input  logic           m_err [ifn-1:0]
);

    //////////////////////////////
    // local signals
    //////////////////////////////

    // transfer strobe on the manager side
    logic trn;

    // select of the transfer whose response is due
    logic [ifl-1:0] rsp_sel;

    //////////////////////////////
    // control
    //////////////////////////////

    // handshake completes when both are high
    assign trn = vld & rdy;

    // remember where the last request went
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            rsp_sel <= '0;
        end else if (trn) begin
            rsp_sel <= sel;
        end
    end

    //////////////////////////////
    // request
    //////////////////////////////

    // payload goes everywhere, valid only to the chosen port
    for (genvar i = 0; i < ifn; i++) begin: gen_req
        assign m_vld[i] = (sel == i[ifl-1:0]) ? vld : 1'b0;
        assign m_wen[i] = wen;
        assign m_adr[i] = adr;
        assign m_byt[i] = byt;
        assign m_wdt[i] = wdt;
    end: gen_req

    //////////////////////////////
    // response
    //////////////////////////////

    // data and error, one cycle behind, so use the registered select
    assign rdt = m_rdt[rsp_sel];
    assign err = m_err[rsp_sel];

    // ready belongs to the live request
    assign rdy = m_rdy[sel];

endmodule: tcb_demultiplexer

//--- logic/tcb_pkg.sv
// shared bus types for the subsystem, imported by every module and the testbench
`include "tcb_cfg_cfg.svh"

package tcb_pkg;

    //////////////////////////////
    // data path
    //////////////////////////////

    // one bus word
    typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

    // byte enables, bit i covers wdt[8*i+:8]
    typedef logic [`TCB_BYT_W-1:0] tcb_byt_t;

    //////////////////////////////
    // address views
    //////////////////////////////

    // memory view, region then byte offset
    typedef struct packed {
        logic [3:0]             region;
        logic [`TCB_ADR_W-5:0]  off;
    } tcb_adr_mem_t;

    // register view, region, reserved, register index, byte lane
    typedef struct packed {
        logic [3:0]             region;
        logic [`TCB_ADR_W-9:0]  rsv;
        logic [1:0]             idx;
        logic [1:0]             lane;
    } tcb_adr_reg_t;

    // same address word, decoded by sram or register block
    typedef union packed {
        tcb_adr_mem_t mem;
        tcb_adr_reg_t rgs;
    } tcb_adr_t;

    // lane merge for byte-enabled writes
    function automatic tcb_dat_t byte_merge(tcb_dat_t old_dat, tcb_dat_t new_dat, tcb_byt_t byt);
        tcb_dat_t res;
        res = old_dat;
        for (int i = 0; i < `TCB_BYT_W; i++) begin
            if (byt[i]) res[8*i +: 8] = new_dat[8*i +: 8];
        end
        return res;
    endfunction

endpackage: tcb_pkg

//--- logic/tcb_regs.sv
// register block subordinate, identification, scratch and cycle counter, errors on anything else
`timescale 1ns/100ps
`include "tcb_cfg_cfg.svh"

module tcb_regs
    import tcb_pkg::*;
(
    // clock and reset
    input  logic     sub,
    input  logic     rst_n,
    // request
    input  logic     vld,
    input  logic     wen,
    input  tcb_adr_t adr,
    input  tcb_byt_t byt,
    input  tcb_dat_t wdt,
    // response
    output logic     rdy,
    output tcb_dat_t rdt,
    output logic     err
);

    //////////////////////////////
    // local signals
    //////////////////////////////

    // register indices
    localparam logic [1:0] idx_id  = 2'd0;
    localparam logic [1:0] idx_scr = 2'd1;
    localparam logic [1:0] idx_cnt = 2'd2;

    // register view of the address
    tcb_adr_reg_t reg_adr;

    // transfer strobe
    logic trn;

    // access checks
    logic region_ok;
    logic idx_ok;
    logic ro_wr;
    logic bad;

    // register contents
    tcb_dat_t scratch;
    tcb_dat_t cnt;

    // read mux output
    tcb_dat_t rd_val;

    //////////////////////////////
    // decode
    //////////////////////////////

    assign reg_adr = adr.rgs;

    // never stalls
    assign rdy = 1'b1;
    assign trn = vld & rdy;

    // only this region is ours
    assign region_ok = (reg_adr.region == `TCB_REGION_REGS);

    // index 3 is not implemented
    assign idx_ok = (reg_adr.idx != 2'd3);

    // id and counter are read-only
    assign ro_wr = wen & ((reg_adr.idx == idx_id) | (reg_adr.idx == idx_cnt));

    // any of these turns the access into an error
    assign bad = ~region_ok | ~idx_ok | ro_wr;

    // read mux
    always_comb begin
        case (reg_adr.idx)
            idx_id:  rd_val = `TCB_REGS_ID;
            idx_scr: rd_val = scratch;
            idx_cnt: rd_val = cnt;
            default: rd_val = '0;
        endcase
    end

    //////////////////////////////
    // registers
    //////////////////////////////

    // scratch, byte-enabled, only on a clean write
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (trn && wen && !bad && (reg_adr.idx == idx_scr)) begin
            scratch <= byte_merge(scratch, wdt, byt);
        end
    end

    // free-running cycle counter
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    //////////////////////////////
    // response
    //////////////////////////////

    // zero data on writes and errors
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            rdt <= '0;
            err <= 1'b0;
        end else if (trn) begin
            rdt <= (wen || bad) ? '0 : rd_val;
            err <= bad;
        end
    end

endmodule: tcb_regs

//--- logic/tcb_sram.sv
// sram subordinate, word-addressed storage with byte-enable writes and one-cycle read latency
`timescale 1ns/100ps
`include "tcb_cfg_cfg.svh"

module tcb_sram
    import tcb_pkg::*;
(
    // clock and reset
    input  logic     sub,
    input  logic     rst_n,
    // request
    input  logic     vld,
    input  logic     wen,
    input  tcb_adr_t adr,
    input  tcb_byt_t byt,
    input  tcb_dat_t wdt,
    // response
    output logic     rdy,
    output tcb_dat_t rdt,
    output logic     err
);

    //////////////////////////////
    // local signals
    //////////////////////////////

    // word index width
    localparam int unsigned aw = $clog2(`TCB_SRAM_DEPTH);

    // storage
    tcb_dat_t mem [0:`TCB_SRAM_DEPTH-1];

    // word index from the memory view
    logic [aw-1:0] idx;

    // transfer strobe
    logic trn;

    //////////////////////////////
    // access
    //////////////////////////////

    // skip byte lane bits
    assign idx = adr.mem.off[2 +: aw];

    // never stalls
    assign rdy = 1'b1;
    assign trn = vld & rdy;

    // writes only touch enabled lanes
    always_ff @(posedge sub) begin
        if (trn && wen) begin
            mem[idx] <= byte_merge(mem[idx], wdt, byt);
        end
    end

    // read word shows up the cycle after the transfer
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            rdt <= '0;
        end else if (trn && !wen) begin
            rdt <= mem[idx];
        end
    end

    // decoder only routes in-range addresses here
    assign err = 1'b0;

endmodule: tcb_sram

//--- logic/tcb_subsystem.sv
// bus subsystem top, one manager port into decoder, demultiplexer, sram and register block
`timescale 1ns/100ps

module tcb_subsystem
    import tcb_pkg::*;
(
    // clock and reset
    input  logic     sub,
    input  logic     rst_n,
    // manager request
    input  logic     vld,
    input  logic     wen,
    input  tcb_adr_t adr,
    input  tcb_byt_t byt,
    input  tcb_dat_t wdt,
    // manager response
    output logic     rdy,
    output tcb_dat_t rdt,
    output logic     err
);

    //////////////////////////////
    // local signals
    //////////////////////////////

    // decoder select
    logic sel;

    // per-port request, 0 is sram and 1 is registers
    logic     m_vld [1:0];
    logic     m_wen [1:0];
    tcb_adr_t m_adr [1:0];
    tcb_byt_t m_byt [1:0];
    tcb_dat_t m_wdt [1:0];

    // per-port response
    logic     m_rdy [1:0];
    tcb_dat_t m_rdt [1:0];
    logic     m_err [1:0];

    //////////////////////////////
    // decode and routing
    //////////////////////////////

    tcb_addr_decoder i_dec (
        .adr (adr),
        .sel (sel)
    );

    tcb_demultiplexer #(
        .ifn (2)
    ) i_dmx (
        .sub   (sub),
        .rst_n (rst_n),
        .sel   (sel),
        .vld   (vld),
        .wen   (wen),
        .adr   (adr),
        .byt   (byt),
        .wdt   (wdt),
        .rdy   (rdy),
        .rdt   (rdt),
        .err   (err),
        .m_vld (m_vld),
        .m_wen (m_wen),
        .m_adr (m_adr),
        .m_byt (m_byt),
        .m_wdt (m_wdt),
        .m_rdy (m_rdy),
        .m_rdt (m_rdt),
        .m_err (m_err)
    );

    //////////////////////////////
    // subordinates
    //////////////////////////////

    // port 0
    tcb_sram i_sram (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (m_vld[0]),
        .wen   (m_wen[0]),
        .adr   (m_adr[0]),
        .byt   (m_byt[0]),
        .wdt   (m_wdt[0]),
        .rdy   (m_rdy[0]),
        .rdt   (m_rdt[0]),
        .err   (m_err[0])
    );

    // port 1
    tcb_regs i_regs (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (m_vld[1]),
        .wen   (m_wen[1]),
        .adr   (m_adr[1]),
        .byt   (m_byt[1]),
        .wdt   (m_wdt[1]),
        .rdy   (m_rdy[1]),
        .rdt   (m_rdt[1]),
        .err   (m_err[1])
    );

endmodule: tcb_subsystem

//--- src.f
+incdir+include
logic/tcb_pkg.sv
logic/tcb_addr_decoder.sv
logic/tcb_demultiplexer.sv
logic/tcb_sram.sv
logic/tcb_regs.sv
logic/tcb_subsystem.sv
tb/tcb_subsystem_tb.sv

//--- tb/tcb_subsystem_tb.sv
// directed testbench for the bus subsystem, run as the simulation top with src.f
`timescale 1ns/100ps
`include "tcb_cfg_cfg.svh"

module tcb_subsystem_tb
    import tcb_pkg::*;
();

    //////////////////////////////
    // setup
    //////////////////////////////

    // clock period in ns, test count for the watchdog, handshake limit in cycles
    localparam int clk_period = 20;
    localparam int n_tests    = 5;
    localparam int max_wait   = 16;

    logic     sub;
    logic     rst_n;
    logic     vld;
    logic     wen;
    tcb_adr_t adr;
    tcb_byt_t byt;
    tcb_dat_t wdt;
    logic     rdy;
    tcb_dat_t rdt;
    logic     err;

    int errors = 0;
    int checks = 0;
    integer seed = 32'h483d;

    // shadow sram and the words written so far
    tcb_dat_t    shadow [0:`TCB_SRAM_DEPTH-1];
    int unsigned known [16];

    tcb_subsystem i_dut (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (vld),
        .wen   (wen),
        .adr   (adr),
        .byt   (byt),
        .wdt   (wdt),
        .rdy   (rdy),
        .rdt   (rdt),
        .err   (err)
    );

    always #(clk_period / 2) sub = ~sub;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // expand enables to a bit mask
    function automatic tcb_dat_t lane_mask(input tcb_byt_t b);
        tcb_dat_t m;
        m = '0;
        for (int i = 0; i < `TCB_BYT_W; i++) begin
            if (b[i]) m[8*i +: 8] = 8'hff;
        end
        return m;
    endfunction

    // byte address of a word in the sram region
    function automatic tcb_adr_t sram_adr(input int unsigned word);
        tcb_adr_t a;
        a.mem.region = `TCB_REGION_SRAM;
        a.mem.off    = {word[9:0], 2'b00};
        return a;
    endfunction

    // register index in any region
    function automatic tcb_adr_t reg_adr(input logic [1:0] idx, input logic [3:0] region);
        tcb_adr_t a;
        a.rgs.region = region;
        a.rgs.rsv    = '0;
        a.rgs.idx    = idx;
        a.rgs.lane   = 2'b00;
        return a;
    endfunction

    task automatic check_dat(input string name, input tcb_dat_t exp_v, input tcb_dat_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("CHECK FAILED t=%0t %s: expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_err(input string name, input logic exp_v, input logic act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("CHECK FAILED t=%0t %s: expected %b, got %b", $time, name, exp_v, act_v);
        end
    endtask

    //////////////////////////////
    // bus tasks
    //////////////////////////////

    // put one request on the bus
    task automatic drive_req(input logic w, input tcb_adr_t a, input tcb_byt_t b,
                             input tcb_dat_t d);
        vld = 1'b1;
        wen = w;
        adr = a;
        byt = b;
        wdt = d;
    endtask

    // returns 1 ns after the transfer edge with the response registered
    task automatic wait_xfer();
        int   n;
        logic hs;
        n  = 0;
        hs = 1'b0;
        while (!hs && n < max_wait) begin
            @(negedge sub);
            hs = rdy;
            @(posedge sub);
            #1;
            n++;
        end
        if (!hs) begin
            errors++;
            $display("no handshake within %0d cycles at t=%0t", max_wait, $time);
        end
    endtask

    task automatic bus_read(input tcb_adr_t a, output tcb_dat_t d, output logic e);
        drive_req(1'b0, a, '1, '0);
        wait_xfer();
        vld = 1'b0;
        d   = rdt;
        e   = err;
    endtask

    task automatic bus_write(input tcb_adr_t a, input tcb_byt_t b, input tcb_dat_t wd,
                             output tcb_dat_t d, output logic e);
        drive_req(1'b1, a, b, wd);
        wait_xfer();
        vld = 1'b0;
        d   = rdt;
        e   = err;
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    // idle outputs and the id register
    task automatic reset_state();
        tcb_dat_t d;
        logic     e;
        check_err("rdy", 1'b1, rdy);
        check_err("err", 1'b0, err);
        check_dat("rdt", '0, rdt);
        bus_read(reg_adr(2'd0, `TCB_REGION_REGS), d, e);
        check_dat("rdt", `TCB_REGS_ID, d);
        check_err("err", 1'b0, e);
    endtask

    task automatic sram_access();
        tcb_dat_t d;
        tcb_dat_t wd;
        logic     e;
        tcb_byt_t pat [4];
        pat = '{4'b0001, 4'b0110, 4'b1000, 4'b0101};
        // full words at random offsets
        for (int i = 0; i < 16; i++) begin
            known[i] = $unsigned($random(seed)) % `TCB_SRAM_DEPTH;
            wd       = $random(seed);
            bus_write(sram_adr(known[i]), 4'hf, wd, d, e);
            shadow[known[i]] = wd;
            check_err("err", 1'b0, e);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(sram_adr(known[i]), d, e);
            check_dat("rdt", shadow[known[i]], d);
            check_err("err", 1'b0, e);
        end
        // partial lanes
        for (int i = 0; i < 4; i++) begin
            wd = $random(seed);
            bus_write(sram_adr(known[i]), pat[i], wd, d, e);
            shadow[known[i]] = (shadow[known[i]] & ~lane_mask(pat[i])) | (wd & lane_mask(pat[i]));
            bus_read(sram_adr(known[i]), d, e);
            check_dat("rdt", shadow[known[i]], d);
        end
    endtask

    // each response checked while the next request is already on the bus
    task automatic back_to_back_reads();
        tcb_adr_t a [8];
        tcb_dat_t x [8];
        logic     xe [8];
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                a[i]  = sram_adr(known[i]);
                x[i]  = shadow[known[i]];
                xe[i] = 1'b0;
            end else if (i % 4 == 1) begin
                a[i]  = reg_adr(2'd0, `TCB_REGION_REGS);
                x[i]  = `TCB_REGS_ID;
                xe[i] = 1'b0;
            end else begin
                // unimplemented index, answered with an error
                a[i]  = reg_adr(2'd3, `TCB_REGION_REGS);
                x[i]  = '0;
                xe[i] = 1'b1;
            end
        end
        drive_req(1'b0, a[0], '1, '0);
        wait_xfer();
        for (int i = 1; i < 8; i++) begin
            drive_req(1'b0, a[i], '1, '0);
            check_dat("rdt", x[i-1], rdt);
            check_err("err", xe[i-1], err);
            wait_xfer();
        end
        vld = 1'b0;
        check_dat("rdt", x[7], rdt);
        check_err("err", xe[7], err);
    endtask

    task automatic scratch_and_counter();
        tcb_dat_t d;
        tcb_dat_t wd;
        tcb_dat_t exp_v;
        tcb_dat_t c1;
        logic     e;
        tcb_adr_t sa;
        sa    = reg_adr(2'd1, `TCB_REGION_REGS);
        exp_v = '0;
        bus_read(sa, d, e);
        check_dat("scratch", exp_v, d);
        wd = $random(seed);
        bus_write(sa, 4'hf, wd, d, e);
        check_err("err", 1'b0, e);
        exp_v = wd;
        bus_read(sa, d, e);
        check_dat("scratch", exp_v, d);
        // single lane update
        wd = $random(seed);
        bus_write(sa, 4'b0010, wd, d, e);
        exp_v = (exp_v & ~lane_mask(4'b0010)) | (wd & lane_mask(4'b0010));
        bus_read(sa, d, e);
        check_dat("scratch", exp_v, d);
        // counter must move forward
        bus_read(reg_adr(2'd2, `TCB_REGION_REGS), c1, e);
        bus_read(reg_adr(2'd2, `TCB_REGION_REGS), d, e);
        checks++;
        if (!(d > c1)) begin
            errors++;
            $display("CHECK FAILED t=%0t cnt: expected above %h, got %h", $time, c1, d);
        end
    endtask

    task automatic error_responses();
        tcb_dat_t d;
        logic     e;
        // beyond the sram words
        bus_read(sram_adr(`TCB_SRAM_DEPTH + 44), d, e);
        check_err("err", 1'b1, e);
        check_dat("rdt", '0, d);
        // unmapped region
        bus_read(reg_adr(2'd0, 4'h5), d, e);
        check_err("err", 1'b1, e);
        check_dat("rdt", '0, d);
        bus_read(reg_adr(2'd3, `TCB_REGION_REGS), d, e);
        check_err("err", 1'b1, e);
        check_dat("rdt", '0, d);
        bus_write(reg_adr(2'd0, `TCB_REGION_REGS), 4'hf, $random(seed), d, e);
        check_err("err", 1'b1, e);
        check_dat("rdt", '0, d);
        // id untouched
        bus_read(reg_adr(2'd0, `TCB_REGION_REGS), d, e);
        check_dat("rdt", `TCB_REGS_ID, d);
        check_err("err", 1'b0, e);
    endtask

    //////////////////////////////
    // run
    //////////////////////////////

    // 200 cycles per test
    initial begin
        #(n_tests * 200 * clk_period);
        $display("watchdog expired, tests did not finish in %0d cycles", n_tests * 200);
        $display("Verification failed");
        $finish;
    end

    initial begin
        sub   = 1'b0;
        rst_n = 1'b0;
        vld   = 1'b0;
        wen   = 1'b0;
        adr   = '0;
        byt   = '0;
        wdt   = '0;
        repeat (5) @(posedge sub);
        #1;
        rst_n = 1'b1;
        reset_state();
        sram_access();
        back_to_back_reads();
        scratch_and_counter();
        error_responses();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule: tcb_subsystem_tb
